/* des_ks_params.svh */
// DES key schedule widths, round count and AXI4-Lite register offsets
`ifndef DES_KS_PARAMS_SVH
`define DES_KS_PARAMS_SVH

`define DES_KEY_W        64
`define DES_HALF_W       28
`define DES_SUBKEY_W     48
`define DES_ROUNDS       16
`define DES_ROUND_IDX_W  4

`define AXIL_ADDR_W      5
`define AXIL_DATA_W      32

// Byte offsets of the register map
`define REG_CTRL         5'h00
`define REG_STATUS       5'h04
`define REG_KEY_HI       5'h08
`define REG_KEY_LO       5'h0C
`define REG_SUBKEY_SEL   5'h10
`define REG_SUBKEY_HI    5'h14
`define REG_SUBKEY_LO    5'h18

`endif

/* des_ks_pkg.sv */
// DES key schedule types, register map and permutation tables
`default_nettype none

`include "des_ks_params.svh"

package des_ks_pkg;

   typedef enum logic [`AXIL_ADDR_W-1:0] {
      ADDR_CTRL       = `REG_CTRL,
      ADDR_STATUS     = `REG_STATUS,
      ADDR_KEY_HI     = `REG_KEY_HI,
      ADDR_KEY_LO     = `REG_KEY_LO,
      ADDR_SUBKEY_SEL = `REG_SUBKEY_SEL,
      ADDR_SUBKEY_HI  = `REG_SUBKEY_HI,
      ADDR_SUBKEY_LO  = `REG_SUBKEY_LO
   } reg_addr_e;

   typedef enum logic {
      KS_IDLE,
      KS_RUN
   } ks_state_e;

   typedef logic [`DES_SUBKEY_W-1:0]    subkey_t;
   typedef logic [`DES_ROUND_IDX_W-1:0] round_idx_t;

   // Bit numbers count from 1 at the MSB, as in the standard
   localparam int PC1_TABLE [56] = '{
      57, 49, 41, 33, 25, 17,  9,
       1, 58, 50, 42, 34, 26, 18,
      10,  2, 59, 51, 43, 35, 27,
      19, 11,  3, 60, 52, 44, 36,   // End of C
      63, 55, 47, 39, 31, 23, 15,
       7, 62, 54, 46, 38, 30, 22,
      14,  6, 61, 53, 45, 37, 29,
      21, 13,  5, 28, 20, 12,  4
   };

   localparam int PC2_TABLE [48] = '{
      14, 17, 11, 24,  1,  5,
       3, 28, 15,  6, 21, 10,
      23, 19, 12,  4, 26,  8,
      16,  7, 27, 20, 13,  2,
      41, 52, 31, 37, 47, 55,
      30, 40, 51, 45, 33, 48,
      44, 49, 39, 56, 34, 53,
      46, 42, 50, 36, 29, 32
   };

   // Left rotation per round, index 0 is round 1
   localparam int SHIFT_TABLE [16] = '{
      1, 1, 2, 2, 2, 2, 2, 2,
      1, 2, 2, 2, 2, 2, 2, 1
   };

endpackage

`default_nettype wire

/* des_subkey_store.sv */
// Sixteen-entry subkey memory, one write port and one registered read port
`timescale 1ns/1ps
`default_nettype none

`include "des_ks_params.svh"

module des_subkey_store (
   input  wire                           clk,
   input  wire                           wr_en,
   input  wire des_ks_pkg::round_idx_t   wr_round,
   input  wire des_ks_pkg::subkey_t      wr_subkey,
   input  wire des_ks_pkg::round_idx_t   rd_round,
   output des_ks_pkg::subkey_t           rd_subkey
);

   des_ks_pkg::subkey_t mem [`DES_ROUNDS];

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_round] <= wr_subkey;
   end

   always_ff @(posedge clk)
   begin
      rd_subkey <= mem[rd_round];   // One cycle read latency
   end

endmodule

`default_nettype wire

/* des_key_schedule.sv */
// Sequential DES key schedule, PC-1 on start then one rotated PC-2 subkey per cycle
`timescale 1ns/1ps
`default_nettype none

`include "des_ks_params.svh"

module des_key_schedule (
   input  wire                           clk,
   input  wire                           reset,
   input  wire                           start,
   input  wire [`DES_KEY_W-1:0]          key,
   output logic                          busy,
   output logic                          done,
   output logic                          wr_en,
   output des_ks_pkg::round_idx_t        wr_round,
   output des_ks_pkg::subkey_t           wr_subkey
);

   des_ks_pkg::ks_state_e     state;
   des_ks_pkg::round_idx_t    round;
   logic                      accept;
   logic [`DES_HALF_W-1:0]    c_q;
   logic [`DES_HALF_W-1:0]    d_q;
   logic [`DES_HALF_W-1:0]    c_rot;
   logic [`DES_HALF_W-1:0]    d_rot;
   logic [2*`DES_HALF_W-1:0]  cd_pc1;
   logic [2*`DES_HALF_W-1:0]  cd_rot;

   assign accept = start && (state == des_ks_pkg::KS_IDLE);   // Start ignored while running

   // PC-1, drops the parity bits
   always_comb
   begin
      for (int i = 0; i < 2*`DES_HALF_W; i++)
      begin
         cd_pc1[2*`DES_HALF_W-1-i] = key[`DES_KEY_W - des_ks_pkg::PC1_TABLE[i]];
      end
   end

   always_comb
   begin
      if (des_ks_pkg::SHIFT_TABLE[round] == 1)
      begin
         c_rot = {c_q[`DES_HALF_W-2:0], c_q[`DES_HALF_W-1]};
         d_rot = {d_q[`DES_HALF_W-2:0], d_q[`DES_HALF_W-1]};
      end
      else
      begin
         c_rot = {c_q[`DES_HALF_W-3:0], c_q[`DES_HALF_W-1 -: 2]};
         d_rot = {d_q[`DES_HALF_W-3:0], d_q[`DES_HALF_W-1 -: 2]};
      end
      cd_rot = {c_rot, d_rot};
   end

   // PC-2 on the rotated halves
   always_comb
   begin
      for (int i = 0; i < `DES_SUBKEY_W; i++)
      begin
         wr_subkey[`DES_SUBKEY_W-1-i] = cd_rot[2*`DES_HALF_W - des_ks_pkg::PC2_TABLE[i]];
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= des_ks_pkg::KS_IDLE;
         round <= '0;
         done  <= 1'b0;
      end
      else
      begin
         case (state)
            des_ks_pkg::KS_IDLE:
            begin
               if (accept)
               begin
                  state <= des_ks_pkg::KS_RUN;
                  round <= '0;
                  done  <= 1'b0;
               end
            end
            des_ks_pkg::KS_RUN:
            begin
               round <= round + 1'b1;
               if (round == des_ks_pkg::round_idx_t'(`DES_ROUNDS - 1))
               begin
                  state <= des_ks_pkg::KS_IDLE;
                  done  <= 1'b1;
               end
            end
            default: state <= des_ks_pkg::KS_IDLE;
         endcase
      end
   end

   // C and D halves
   always_ff @(posedge clk)
   begin
      if (accept)
         {c_q, d_q} <= cd_pc1;
      else if (state == des_ks_pkg::KS_RUN)
         {c_q, d_q} <= cd_rot;
   end

   assign busy     = (state == des_ks_pkg::KS_RUN);
   assign wr_en    = busy;
   assign wr_round = round;

   // Sixteen writes back to back, then done with the engine idle
   a_run_len: assert property (@(posedge clk) disable iff (reset)
      accept |=> (wr_en && state == des_ks_pkg::KS_RUN) [*`DES_ROUNDS] ##1 (!wr_en && done));

   a_round_clr: assert property (@(posedge clk) disable iff (reset)
      accept |=> (round == '0) && busy && !done);

endmodule

`default_nettype wire

/* des_ks_regs.sv */
// AXI4-Lite slave with control, status, key and subkey select registers
`timescale 1ns/1ps
`default_nettype none

`include "des_ks_params.svh"

module des_ks_regs (
   input  wire                            clk,
   input  wire                            reset,
   input  wire [`AXIL_ADDR_W-1:0]         awaddr,
   input  wire                            awvalid,
   output logic                           awready,
   input  wire [`AXIL_DATA_W-1:0]         wdata,
   input  wire [`AXIL_DATA_W/8-1:0]       wstrb,
   input  wire                            wvalid,
   output logic                           wready,
   output logic [1:0]                     bresp,
   output logic                           bvalid,
   input  wire                            bready,
   input  wire [`AXIL_ADDR_W-1:0]         araddr,
   input  wire                            arvalid,
   output logic                           arready,
   output logic [`AXIL_DATA_W-1:0]        rdata,
   output logic [1:0]                     rresp,
   output logic                           rvalid,
   input  wire                            rready,
   input  wire                            busy,
   input  wire                            done,
   input  wire des_ks_pkg::subkey_t       rd_subkey,
   output logic                           start,
   output logic [`DES_KEY_W-1:0]          key,
   output des_ks_pkg::round_idx_t         rd_round
);

   des_ks_pkg::reg_addr_e     wr_reg;
   des_ks_pkg::reg_addr_e     rd_reg;
   des_ks_pkg::round_idx_t    sel;
   logic                      decrypt;   // CTRL bit 1
   logic                      wr_fire;
   logic                      rd_fire;
   logic                      wr_ok;
   logic                      rd_ok;
   logic [`AXIL_DATA_W-1:0]   rd_data;
   logic [`AXIL_DATA_W-1:0]   key_hi;
   logic [`AXIL_DATA_W-1:0]   key_lo;

   assign wr_reg  = des_ks_pkg::reg_addr_e'(awaddr);
   assign rd_reg  = des_ks_pkg::reg_addr_e'(araddr);
   assign wr_fire = awvalid && awready && wvalid && wready;
   assign rd_fire = arvalid && arready;
   assign key     = {key_hi, key_lo};

   // Decrypt order reads the rounds back to front
   assign rd_round = decrypt ? des_ks_pkg::round_idx_t'(`DES_ROUNDS - 1) - sel : sel;

   always_comb
   begin
      case (wr_reg)
         des_ks_pkg::ADDR_CTRL, des_ks_pkg::ADDR_STATUS,
         des_ks_pkg::ADDR_KEY_HI, des_ks_pkg::ADDR_KEY_LO,
         des_ks_pkg::ADDR_SUBKEY_SEL, des_ks_pkg::ADDR_SUBKEY_HI,
         des_ks_pkg::ADDR_SUBKEY_LO: wr_ok = 1'b1;
         default:                    wr_ok = 1'b0;
      endcase
   end

   always_comb
   begin
      rd_data = '0;
      rd_ok   = 1'b1;
      case (rd_reg)
         des_ks_pkg::ADDR_CTRL:       rd_data[1] = decrypt;
         des_ks_pkg::ADDR_STATUS:     rd_data[1:0] = {done, busy};
         des_ks_pkg::ADDR_KEY_HI:     rd_data = key_hi;
         des_ks_pkg::ADDR_KEY_LO:     rd_data = key_lo;
         des_ks_pkg::ADDR_SUBKEY_SEL: rd_data[`DES_ROUND_IDX_W-1:0] = sel;
         des_ks_pkg::ADDR_SUBKEY_HI:  rd_data[15:0] = rd_subkey[`DES_SUBKEY_W-1:32];
         des_ks_pkg::ADDR_SUBKEY_LO:  rd_data = rd_subkey[31:0];
         default:                     rd_ok = 1'b0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
         bresp   <= 2'b00;
         arready <= 1'b0;
         rvalid  <= 1'b0;
         start   <= 1'b0;
         decrypt <= 1'b0;
         sel     <= '0;
      end
      else
      begin
         start   <= 1'b0;
         awready <= 1'b0;
         wready  <= 1'b0;
         arready <= 1'b0;
         if (awvalid && wvalid && !awready && !bvalid)
         begin
            awready <= 1'b1;
            wready  <= 1'b1;
         end
         if (wr_fire)
         begin
            bvalid <= 1'b1;
            bresp  <= wr_ok ? 2'b00 : 2'b10;   // OKAY or SLVERR
            if (wr_reg == des_ks_pkg::ADDR_CTRL && wstrb[0])
            begin
               decrypt <= wdata[1];
               start   <= wdata[0] && !busy;
            end
            if (wr_reg == des_ks_pkg::ADDR_SUBKEY_SEL && wstrb[0])
               sel <= wdata[`DES_ROUND_IDX_W-1:0];
         end
         else if (bvalid && bready)
            bvalid <= 1'b0;

         if (arvalid && !arready && !rvalid)
            arready <= 1'b1;
         if (rd_fire)
            rvalid <= 1'b1;
         else if (rvalid && rready)
            rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rd_fire)
      begin
         rdata <= rd_data;
         rresp <= rd_ok ? 2'b00 : 2'b10;
      end
   end

   // Key bytes follow the write strobes
   always_ff @(posedge clk)
   begin
      if (wr_fire)
      begin
         for (int b = 0; b < `AXIL_DATA_W/8; b++)
         begin
            if (wstrb[b] && wr_reg == des_ks_pkg::ADDR_KEY_HI)
               key_hi[8*b +: 8] <= wdata[8*b +: 8];
            if (wstrb[b] && wr_reg == des_ks_pkg::ADDR_KEY_LO)
               key_lo[8*b +: 8] <= wdata[8*b +: 8];
         end
      end
   end

   a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
      bvalid && !bready |=> bvalid);

   a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
      rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

/* des_ks_top.sv */
// DES key schedule top, AXI4-Lite registers around the schedule engine and subkey store
`timescale 1ns/1ps
`default_nettype none

`include "des_ks_params.svh"

module des_ks_top (
   input  wire                        clk,
   input  wire                        reset,
   input  wire [`AXIL_ADDR_W-1:0]     awaddr,
   input  wire                        awvalid,
   output logic                       awready,
   input  wire [`AXIL_DATA_W-1:0]     wdata,
   input  wire [`AXIL_DATA_W/8-1:0]   wstrb,
   input  wire                        wvalid,
   output logic                       wready,
   output logic [1:0]                 bresp,
   output logic                       bvalid,
   input  wire                        bready,
   input  wire [`AXIL_ADDR_W-1:0]     araddr,
   input  wire                        arvalid,
   output logic                       arready,
   output logic [`AXIL_DATA_W-1:0]    rdata,
   output logic [1:0]                 rresp,
   output logic                       rvalid,
   input  wire                        rready
);

   logic                      start;
   logic                      busy;
   logic                      done;
   logic [`DES_KEY_W-1:0]     key;
   logic                      wr_en;
   des_ks_pkg::round_idx_t    wr_round;
   des_ks_pkg::subkey_t       wr_subkey;
   des_ks_pkg::round_idx_t    rd_round;
   des_ks_pkg::subkey_t       rd_subkey;

   des_ks_regs u_regs (
      .clk       (clk),
      .reset     (reset),
      .awaddr    (awaddr),
      .awvalid   (awvalid),
      .awready   (awready),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .wvalid    (wvalid),
      .wready    (wready),
      .bresp     (bresp),
      .bvalid    (bvalid),
      .bready    (bready),
      .araddr    (araddr),
      .arvalid   (arvalid),
      .arready   (arready),
      .rdata     (rdata),
      .rresp     (rresp),
      .rvalid    (rvalid),
      .rready    (rready),
      .busy      (busy),
      .done      (done),
      .rd_subkey (rd_subkey),
      .start     (start),
      .key       (key),
      .rd_round  (rd_round)
   );

   des_key_schedule u_sched (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .key       (key),
      .busy      (busy),
      .done      (done),
      .wr_en     (wr_en),
      .wr_round  (wr_round),
      .wr_subkey (wr_subkey)
   );

   des_subkey_store u_store (
      .clk       (clk),
      .wr_en     (wr_en),
      .wr_round  (wr_round),
      .wr_subkey (wr_subkey),
      .rd_round  (rd_round),
      .rd_subkey (rd_subkey)
   );

endmodule

`default_nettype wire

/* tb_des_ks.sv */
// Testbench for the DES key schedule behind its AXI4-Lite register block
`timescale 1ns/1ps
`default_nettype none

`include "des_ks_params.svh"

module tb_des_ks;

   localparam int WAIT_LIMIT = 200;

   logic                        clk = 1'b0;
   logic                        reset;
   logic [`AXIL_ADDR_W-1:0]     awaddr;
   logic                        awvalid;
   logic                        awready;
   logic [`AXIL_DATA_W-1:0]     wdata;
   logic [`AXIL_DATA_W/8-1:0]   wstrb;
   logic                        wvalid;
   logic                        wready;
   logic [1:0]                  bresp;
   logic                        bvalid;
   logic                        bready;
   logic [`AXIL_ADDR_W-1:0]     araddr;
   logic                        arvalid;
   logic                        arready;
   logic [`AXIL_DATA_W-1:0]     rdata;
   logic [1:0]                  rresp;
   logic                        rvalid;
   logic                        rready;

   des_ks_pkg::subkey_t         exp_sk [`DES_ROUNDS];
   des_ks_pkg::subkey_t         got_q [$];
   des_ks_pkg::subkey_t         want_q [$];
   string                       tag_q [$];

   des_ks_top DUT (.*);

   always #50 clk = ~clk;

   task automatic stop_run();
      $display("Verification failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic timed_out(input string what);
      $display("Timed out waiting for %s at %0t", what, $time);
      stop_run();
   endtask

   task automatic check_subkey(input des_ks_pkg::subkey_t got,
                               input des_ks_pkg::subkey_t want, input string what);
      if (got !== want)
      begin
         $display("FAIL %0t: %s got %012h expected %012h", $time, what, got, want);
         stop_run();
      end
   endtask

   task automatic check_status(input logic [`AXIL_DATA_W-1:0] got,
                               input logic [`AXIL_DATA_W-1:0] want, input string what);
      if (got !== want)
      begin
         $display("FAIL %0t: %s got %08h expected %08h", $time, what, got, want);
         stop_run();
      end
   endtask

   task automatic check_resp(input logic [1:0] got, input logic [1:0] want, input string what);
      if (got !== want)
      begin
         $display("FAIL %0t: %s got %02b expected %02b", $time, what, got, want);
         stop_run();
      end
   endtask

   // All 16 subkeys of a key, straight from the standard tables
   function automatic void ref_subkeys(input logic [`DES_KEY_W-1:0] k);
      logic [`DES_HALF_W-1:0]   c;
      logic [`DES_HALF_W-1:0]   d;
      logic [2*`DES_HALF_W-1:0] cd;
      for (int i = 0; i < 2*`DES_HALF_W; i++)
         cd[2*`DES_HALF_W-1-i] = k[`DES_KEY_W - des_ks_pkg::PC1_TABLE[i]];
      c = cd[2*`DES_HALF_W-1:`DES_HALF_W];
      d = cd[`DES_HALF_W-1:0];
      for (int r = 0; r < `DES_ROUNDS; r++)
      begin
         for (int s = 0; s < des_ks_pkg::SHIFT_TABLE[r]; s++)
         begin
            c = {c[`DES_HALF_W-2:0], c[`DES_HALF_W-1]};   // One bit at a time
            d = {d[`DES_HALF_W-2:0], d[`DES_HALF_W-1]};
         end
         cd = {c, d};
         for (int i = 0; i < `DES_SUBKEY_W; i++)
            exp_sk[r][`DES_SUBKEY_W-1-i] = cd[2*`DES_HALF_W - des_ks_pkg::PC2_TABLE[i]];
      end
   endfunction

   task automatic axi_write(input logic [`AXIL_ADDR_W-1:0] addr,
                            input logic [`AXIL_DATA_W-1:0] data);
      int n;
      n = 0;
      @(posedge clk);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= data;
      wstrb   <= '1;
      wvalid  <= 1'b1;
      bready  <= 1'b1;
      @(negedge clk);
      while (!(awready && wready))
      begin
         n++;
         if (n > WAIT_LIMIT)
            timed_out("awready and wready");
         @(negedge clk);
      end
      @(posedge clk);   // Handshake edge
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      n = 0;
      @(negedge clk);
      while (!bvalid)
      begin
         n++;
         if (n > WAIT_LIMIT)
            timed_out("bvalid");
         @(negedge clk);
      end
      check_resp(bresp, 2'b00, "write response");
      @(posedge clk);
      bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [`AXIL_ADDR_W-1:0] addr,
                           output logic [`AXIL_DATA_W-1:0] data, output logic [1:0] resp);
      int n;
      n = 0;
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      rready  <= 1'b1;
      @(negedge clk);
      while (!arready)
      begin
         n++;
         if (n > WAIT_LIMIT)
            timed_out("arready");
         @(negedge clk);
      end
      @(posedge clk);
      arvalid <= 1'b0;
      n = 0;
      @(negedge clk);
      while (!rvalid)
      begin
         n++;
         if (n > WAIT_LIMIT)
            timed_out("rvalid");
         @(negedge clk);
      end
      data = rdata;
      resp = rresp;
      @(posedge clk);
      rready <= 1'b0;
   endtask

   // Select must land before the subkey reads
   task automatic read_subkey(input des_ks_pkg::round_idx_t sel, output des_ks_pkg::subkey_t sk);
      logic [`AXIL_DATA_W-1:0] hi;
      logic [`AXIL_DATA_W-1:0] lo;
      logic [1:0]              resp;
      axi_write(`REG_SUBKEY_SEL, `AXIL_DATA_W'(sel));
      axi_read(`REG_SUBKEY_HI, hi, resp);
      check_resp(resp, 2'b00, "subkey high response");
      axi_read(`REG_SUBKEY_LO, lo, resp);
      check_resp(resp, 2'b00, "subkey low response");
      sk = {hi[15:0], lo};
   endtask

   task automatic queue_compare(input des_ks_pkg::subkey_t got,
                                input des_ks_pkg::subkey_t want, input string tag);
      got_q.push_back(got);
      want_q.push_back(want);
      tag_q.push_back(tag);
   endtask

   task automatic wait_done();
      logic [`AXIL_DATA_W-1:0] data;
      logic [1:0]              resp;
      int                      n;
      n = 0;
      axi_read(`REG_STATUS, data, resp);
      while (!data[1])
      begin
         n++;
         if (n > WAIT_LIMIT)
            timed_out("done");
         axi_read(`REG_STATUS, data, resp);
      end
   endtask

   task automatic run_schedule(input logic [`DES_KEY_W-1:0] k);
      axi_write(`REG_KEY_HI, k[63:32]);
      axi_write(`REG_KEY_LO, k[31:0]);
      axi_write(`REG_CTRL, 32'h1);
      wait_done();
   endtask

   // Decrypt order expects the reference list back to front
   task automatic collect_subkeys(input string what, input bit rev);
      des_ks_pkg::subkey_t sk;
      for (int n = 0; n < `DES_ROUNDS; n++)
      begin
         read_subkey(des_ks_pkg::round_idx_t'(n), sk);
         queue_compare(sk, rev ? exp_sk[`DES_ROUNDS-1-n] : exp_sk[n],
                       $sformatf("%s select %0d", what, n));
      end
   endtask

   initial
   begin
      forever
      begin
         @(negedge clk);
         while (got_q.size() > 0)
            check_subkey(got_q.pop_front(), want_q.pop_front(), tag_q.pop_front());
      end
   end

   initial
   begin
      logic [`AXIL_DATA_W-1:0] data;
      logic [1:0]              resp;
      logic [`DES_KEY_W-1:0]   key_a;
      logic [`DES_KEY_W-1:0]   key_b;
      des_ks_pkg::subkey_t     sk;
      int                      n;

      void'($urandom(21283));
      reset   = 1'b1;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_resp({bvalid, rvalid}, 2'b00, "bvalid and rvalid after reset");
      axi_read(`REG_STATUS, data, resp);
      check_status(data, 32'h0, "status after reset");

      // FIPS example key
      key_a = 64'h133457799BBCDFF1;
      ref_subkeys(key_a);
      check_subkey(exp_sk[0], 48'h1B02EFFC7072, "reference round 1");
      check_subkey(exp_sk[15], 48'hCB3D8B0E17F5, "reference round 16");
      run_schedule(key_a);
      read_subkey(4'd0, sk);
      queue_compare(sk, 48'h1B02EFFC7072, "known answer round 1");
      read_subkey(4'd15, sk);
      queue_compare(sk, 48'hCB3D8B0E17F5, "known answer round 16");

      for (int i = 0; i < 20; i++)
      begin
         key_a = {$urandom, $urandom};
         ref_subkeys(key_a);
         run_schedule(key_a);
         collect_subkeys($sformatf("random key %0d", i), 1'b0);
      end

      axi_write(`REG_CTRL, 32'h2);   // Decrypt order, no start
      collect_subkeys("decrypt order", 1'b1);
      axi_write(`REG_CTRL, 32'h0);

      key_a = {$urandom, $urandom};
      key_b = ~key_a;
      ref_subkeys(key_a);
      axi_write(`REG_KEY_HI, key_a[63:32]);
      axi_write(`REG_KEY_LO, key_a[31:0]);
      axi_write(`REG_CTRL, 32'h1);
      axi_read(`REG_STATUS, data, resp);
      check_status(data, 32'h1, "status right after start");
      axi_write(`REG_KEY_HI, key_b[63:32]);
      axi_write(`REG_KEY_LO, key_b[31:0]);
      axi_write(`REG_CTRL, 32'h1);   // Lands while busy
      wait_done();
      axi_read(`REG_STATUS, data, resp);
      check_status(data, 32'h2, "status after run");
      collect_subkeys("key written while busy", 1'b0);

      axi_read(5'h1C, data, resp);
      check_resp(resp, 2'b10, "unmapped read response");
      check_status(data, 32'h0, "unmapped read data");

      n = 0;
      while (got_q.size() > 0)
      begin
         n++;
         if (n > WAIT_LIMIT)
            timed_out("pending subkey compares");
         @(posedge clk);
      end
      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
des_ks_pkg.sv
des_subkey_store.sv
des_key_schedule.sv
des_ks_regs.sv
des_ks_top.sv
tb_des_ks.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_des_ks
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
